// File: logic/tmds_config.svh
`ifndef TMDS_CONFIG_SVH
`define TMDS_CONFIG_SVH

// horizontal raster in pixels, 24 per line
`define TMDS_H_ACTIVE 16
`define TMDS_H_FRONT 2
`define TMDS_H_SYNC 3
`define TMDS_H_BACK 3

// vertical raster in lines, 8 per frame
`define TMDS_V_ACTIVE 4
`define TMDS_V_FRONT 1
`define TMDS_V_SYNC 1
`define TMDS_V_BACK 2

// serial word length, one bit per i_clk
`define TMDS_SYMBOL_BITS 10

`endif

// File: logic/tmds_pkg.sv
`include "tmds_config.svh"

package tmds_pkg;

    // one colour component
    typedef logic [7:0] t_pixel;

    // encoded word as it goes onto a lane
    typedef logic [`TMDS_SYMBOL_BITS-1:0] t_symbol;

    // bit 0 is hsync, bit 1 is vsync
    typedef logic [1:0] t_ctrl;

    // running balance in half units, bit 3 is the sign
    typedef logic [3:0] t_disparity;

    // raster phases, used for both the line and the frame
    typedef enum logic [1:0] {
        ACTIVE,
        FRONT,
        SYNC,
        BACK
    } t_phase;

endpackage

// File: logic/video_timing.sv
`timescale 1ns/1ps
`include "tmds_config.svh"

module video_timing (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_pix_strobe,
    output logic            o_blanking,
    output tmds_pkg::t_ctrl o_ctrl
);
    import tmds_pkg::*;

    logic [4:0] h_count;
    logic [4:0] h_count_next;
    logic [4:0] v_count;
    logic [4:0] v_count_next;
    t_phase     h_phase;
    t_phase     h_phase_next;
    t_phase     v_phase;
    t_phase     v_phase_next;
    logic       h_wrap;
    logic       line_end;
    logic       blanking_next;
    t_ctrl      ctrl_next;

    // last count value of each phase
    function automatic logic [4:0] h_last(input t_phase phase);
        case (phase)
            ACTIVE:  h_last = 5'(`TMDS_H_ACTIVE - 1);
            FRONT:   h_last = 5'(`TMDS_H_FRONT - 1);
            SYNC:    h_last = 5'(`TMDS_H_SYNC - 1);
            default: h_last = 5'(`TMDS_H_BACK - 1);
        endcase
    endfunction

    function automatic logic [4:0] v_last(input t_phase phase);
        case (phase)
            ACTIVE:  v_last = 5'(`TMDS_V_ACTIVE - 1);
            FRONT:   v_last = 5'(`TMDS_V_FRONT - 1);
            SYNC:    v_last = 5'(`TMDS_V_SYNC - 1);
            default: v_last = 5'(`TMDS_V_BACK - 1);
        endcase
    endfunction

    function automatic t_phase phase_step(input t_phase phase);
        case (phase)
            ACTIVE:  phase_step = FRONT;
            FRONT:   phase_step = SYNC;
            SYNC:    phase_step = BACK;
            default: phase_step = ACTIVE;
        endcase
    endfunction

    always_comb begin
        h_wrap = (h_count == h_last(h_phase));
        // a line ends when the back porch runs out
        line_end = h_wrap && (h_phase == BACK);

        h_count_next = h_wrap ? 5'd0 : h_count + 5'd1;
        h_phase_next = h_wrap ? phase_step(h_phase) : h_phase;

        v_count_next = v_count;
        v_phase_next = v_phase;
        if (line_end) begin
            if (v_count == v_last(v_phase)) begin
                v_count_next = '0;
                v_phase_next = phase_step(v_phase);
            end else begin
                v_count_next = v_count + 5'd1;
            end
        end

        blanking_next = !((h_phase_next == ACTIVE) && (v_phase_next == ACTIVE));
        ctrl_next = {v_phase_next == SYNC, h_phase_next == SYNC};
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            h_count <= '0;
            v_count <= '0;
            h_phase <= ACTIVE;
            v_phase <= ACTIVE;
            o_blanking <= 1'b0;
            o_ctrl <= '0;
        end else if (i_pix_strobe) begin
            h_count <= h_count_next;
            v_count <= v_count_next;
            h_phase <= h_phase_next;
            v_phase <= v_phase_next;
            // outputs follow the new state so they stay put for the word
            o_blanking <= blanking_next;
            o_ctrl <= ctrl_next;
        end
    end

endmodule

// File: logic/tmds_gen.sv
`timescale 1ns/1ps

// 8-bit pixel to 10-bit TMDS symbol
// q_m[8] marks xor (1) or xnor (0), bit 9 marks an inverted data byte
module tmds_gen (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_pix_en,
    input  tmds_pkg::t_pixel  i_data,
    input  tmds_pkg::t_ctrl   i_control_data,
    input  logic              i_blanking,
    output tmds_pkg::t_symbol o_encoded
);
    import tmds_pkg::*;

    logic [3:0] ones_count;
    logic       use_xor;
    logic [8:0] q_m;
    t_disparity word_disp;
    t_disparity balance;
    t_disparity balance_next;
    t_symbol    symbol;
    t_symbol    symbol_next;

    function automatic logic [3:0] count_ones(input logic [7:0] value);
        logic [3:0] total;
        total = '0;
        for (int i = 0; i < 8; i++) begin
            total = total + 4'(value[i]);
        end
        return total;
    endfunction

    // chained xor or xnor to cut down the transitions
    function automatic logic [8:0] min_transitions(input t_pixel d, input logic xor_mode);
        logic [8:0] word;
        word[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            word[i] = xor_mode ? (word[i-1] ^ d[i]) : ~(word[i-1] ^ d[i]);
        end
        word[8] = xor_mode;
        return word;
    endfunction

    always_comb begin
        ones_count = count_ones(i_data);
        // xor below four ones, or at four with bit 0 set
        use_xor = (ones_count < 4'd4) || ((ones_count == 4'd4) && i_data[0]);
        q_m = min_transitions(i_data, use_xor);
        // ones minus four, half of ones minus zeros
        word_disp = count_ones(q_m[7:0]) - 4'd4;

        if (i_blanking) begin
            case (i_control_data)
                2'b00:   symbol_next = 10'b1101010100;
                2'b01:   symbol_next = 10'b0010101011;
                2'b10:   symbol_next = 10'b0101010100;
                default: symbol_next = 10'b1010101011;
            endcase
            balance_next = '0;
        end else if ((balance == '0) || (word_disp == '0)) begin
            if (q_m[8]) begin
                symbol_next = {2'b01, q_m[7:0]};
                balance_next = balance + word_disp;
            end else begin
                symbol_next = {2'b10, ~q_m[7:0]};
                balance_next = balance - word_disp;
            end
        end else if (balance[3] == word_disp[3]) begin
            // same sign, invert to pull the balance back
            symbol_next = {1'b1, q_m[8], ~q_m[7:0]};
            balance_next = balance + t_disparity'(q_m[8]) - word_disp;
        end else begin
            symbol_next = {1'b0, q_m[8], q_m[7:0]};
            balance_next = balance - t_disparity'(!q_m[8]) + word_disp;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            symbol <= '0;
            balance <= '0;
        end else if (i_pix_en) begin
            symbol <= symbol_next;
            balance <= balance_next;
        end
    end

    assign o_encoded = symbol;

endmodule

// File: logic/tmds_serializer.sv
`timescale 1ns/1ps
`include "tmds_config.svh"

module tmds_serializer (
    input  logic              i_clk,
    input  logic              i_rst,
    input  tmds_pkg::t_symbol i_sym_blue,
    input  tmds_pkg::t_symbol i_sym_green,
    input  tmds_pkg::t_symbol i_sym_red,
    output logic              o_pix_strobe,
    output logic              o_tmds_d0,
    output logic              o_tmds_d1,
    output logic              o_tmds_d2,
    output logic              o_tmds_clk
);
    import tmds_pkg::*;

    localparam int LANES = 4;
    localparam logic [3:0] LAST_BIT = 4'(`TMDS_SYMBOL_BITS - 1);
    // five high bits then five low, sent lsb first
    localparam t_symbol CLK_PATTERN = 10'b0000011111;

    logic [3:0] bit_count;
    t_symbol    load_word [LANES];
    t_symbol    shift_reg [LANES];

    assign o_pix_strobe = (bit_count == LAST_BIT);

    // lane order is blue, green, red, clock
    always_comb begin
        load_word[0] = i_sym_blue;
        load_word[1] = i_sym_green;
        load_word[2] = i_sym_red;
        load_word[3] = CLK_PATTERN;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            bit_count <= '0;
            for (int i = 0; i < LANES; i++) begin
                shift_reg[i] <= '0;
            end
        end else begin
            bit_count <= o_pix_strobe ? 4'd0 : bit_count + 4'd1;
            for (int i = 0; i < LANES; i++) begin
                if (o_pix_strobe) begin
                    shift_reg[i] <= load_word[i];
                end else begin
                    shift_reg[i] <= {1'b0, shift_reg[i][`TMDS_SYMBOL_BITS-1:1]};
                end
            end
        end
    end

    assign o_tmds_d0 = shift_reg[0][0];
    assign o_tmds_d1 = shift_reg[1][0];
    assign o_tmds_d2 = shift_reg[2][0];
    assign o_tmds_clk = shift_reg[3][0];

endmodule

// File: logic/dvi_tx_top.sv
`timescale 1ns/1ps

module dvi_tx_top (
    input  logic             i_clk,
    input  logic             i_rst,
    input  tmds_pkg::t_pixel i_red,
    input  tmds_pkg::t_pixel i_green,
    input  tmds_pkg::t_pixel i_blue,
    output logic             o_pix_strobe,
    output logic             o_tmds_d0,
    output logic             o_tmds_d1,
    output logic             o_tmds_d2,
    output logic             o_tmds_clk
);
    // green and red carry no sync
    localparam tmds_pkg::t_ctrl CTRL_IDLE = 2'b00;

    logic              pix_strobe;
    logic              blanking;
    tmds_pkg::t_ctrl   ctrl;
    tmds_pkg::t_symbol sym_blue;
    tmds_pkg::t_symbol sym_green;
    tmds_pkg::t_symbol sym_red;

    video_timing u_timing (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_pix_strobe(pix_strobe),
        .o_blanking  (blanking),
        .o_ctrl      (ctrl)
    );

    tmds_gen enc_blue (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_pix_en      (pix_strobe),
        .i_data        (i_blue),
        .i_control_data(ctrl),
        .i_blanking    (blanking),
        .o_encoded     (sym_blue)
    );

    tmds_gen enc_green (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_pix_en      (pix_strobe),
        .i_data        (i_green),
        .i_control_data(CTRL_IDLE),
        .i_blanking    (blanking),
        .o_encoded     (sym_green)
    );

    tmds_gen enc_red (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_pix_en      (pix_strobe),
        .i_data        (i_red),
        .i_control_data(CTRL_IDLE),
        .i_blanking    (blanking),
        .o_encoded     (sym_red)
    );

    tmds_serializer u_serializer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_sym_blue  (sym_blue),
        .i_sym_green (sym_green),
        .i_sym_red   (sym_red),
        .o_pix_strobe(pix_strobe),
        .o_tmds_d0   (o_tmds_d0),
        .o_tmds_d1   (o_tmds_d1),
        .o_tmds_d2   (o_tmds_d2),
        .o_tmds_clk  (o_tmds_clk)
    );

    assign o_pix_strobe = pix_strobe;

endmodule

// File: verification/tmds_ref_model.svh
`ifndef TMDS_REF_MODEL_SVH
`define TMDS_REF_MODEL_SVH

localparam int H_TOTAL = `TMDS_H_ACTIVE + `TMDS_H_FRONT + `TMDS_H_SYNC + `TMDS_H_BACK;
localparam int V_TOTAL = `TMDS_V_ACTIVE + `TMDS_V_FRONT + `TMDS_V_SYNC + `TMDS_V_BACK;
localparam int FRAME_PIXELS = H_TOTAL * V_TOTAL;

// raster position of the next word, and running disparity in whole bits
int model_pos;
int model_cnt [3];

function automatic logic pos_blanking(input int pos);
    return !(((pos % H_TOTAL) < `TMDS_H_ACTIVE) && ((pos / H_TOTAL) < `TMDS_V_ACTIVE));
endfunction

// bit 1 vsync, bit 0 hsync
function automatic logic [1:0] pos_sync(input int pos);
    int h;
    int v;
    h = pos % H_TOTAL;
    v = pos / H_TOTAL;
    return {(v >= `TMDS_V_ACTIVE + `TMDS_V_FRONT) &&
                (v < `TMDS_V_ACTIVE + `TMDS_V_FRONT + `TMDS_V_SYNC),
            (h >= `TMDS_H_ACTIVE + `TMDS_H_FRONT) &&
                (h < `TMDS_H_ACTIVE + `TMDS_H_FRONT + `TMDS_H_SYNC)};
endfunction

function automatic int ones_in(input logic [7:0] value);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++) begin
        if (value[i]) n++;
    end
    return n;
endfunction

// stage one of the DVI encoder, bit 8 set when xor was used
function automatic logic [8:0] transition_min(input logic [7:0] d);
    logic [8:0] q;
    logic       use_xnor;
    use_xnor = (ones_in(d) > 4) || ((ones_in(d) == 4) && !d[0]);
    q[0] = d[0];
    for (int i = 1; i < 8; i++) begin
        q[i] = use_xnor ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
    end
    q[8] = !use_xnor;
    return q;
endfunction

function automatic logic [9:0] control_symbol(input logic [1:0] code);
    case (code)
        2'b00:   return 10'b1101010100;
        2'b01:   return 10'b0010101011;
        2'b10:   return 10'b0101010100;
        default: return 10'b1010101011;
    endcase
endfunction

task automatic encode_channel(input int ch, input logic [7:0] d, input logic blank,
                              input logic [1:0] code, output logic [9:0] sym);
    logic [8:0] qm;
    int         n1;
    int         n0;
    qm = transition_min(d);
    n1 = ones_in(qm[7:0]);
    n0 = 8 - n1;
    if (blank) begin
        sym = control_symbol(code);
        model_cnt[ch] = 0;
    end else if ((model_cnt[ch] == 0) || (n1 == n0)) begin
        sym = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        model_cnt[ch] += qm[8] ? (n1 - n0) : (n0 - n1);
    end else if ((model_cnt[ch] > 0 && n1 > n0) || (model_cnt[ch] < 0 && n0 > n1)) begin
        sym = {1'b1, qm[8], ~qm[7:0]};
        model_cnt[ch] += (qm[8] ? 2 : 0) + n0 - n1;
    end else begin
        sym = {1'b0, qm[8], qm[7:0]};
        model_cnt[ch] += n1 - n0 - (qm[8] ? 0 : 2);
    end
endtask

// entry is {active, red, green, blue}
task automatic model_word(input logic [7:0] red, input logic [7:0] green,
                          input logic [7:0] blue, output logic [30:0] entry);
    logic       blank;
    logic [9:0] sym_b;
    logic [9:0] sym_g;
    logic [9:0] sym_r;
    blank = pos_blanking(model_pos);
    encode_channel(0, blue, blank, pos_sync(model_pos), sym_b);
    encode_channel(1, green, blank, 2'b00, sym_g);
    encode_channel(2, red, blank, 2'b00, sym_r);
    entry = {!blank, sym_r, sym_g, sym_b};
    model_pos = (model_pos + 1) % FRAME_PIXELS;
endtask

`endif

// File: verification/tb_dvi_tx.sv
`timescale 1ns/1ps
`include "tmds_config.svh"

module tb_dvi_tx;

    `include "tmds_ref_model.svh"

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int SYMBOL_BITS = `TMDS_SYMBOL_BITS;
    localparam logic [9:0] CLK_PATTERN = 10'b0000011111;
    // two full frames after the two reset words
    localparam int TOTAL_WORDS = 2 * FRAME_PIXELS + 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 3 * FRAME_PIXELS * SYMBOL_BITS + 200;

    logic       i_clk;
    logic       i_rst;
    logic [7:0] i_red;
    logic [7:0] i_green;
    logic [7:0] i_blue;
    logic       o_pix_strobe;
    logic       o_tmds_d0;
    logic       o_tmds_d1;
    logic       o_tmds_d2;
    logic       o_tmds_clk;

    int          seed;
    int          errors;
    int          checks;
    int          words_done;
    int          since_strobe;
    bit          drive_pending;
    logic [9:0]  lane_word [4];
    int          lane_disp [3];
    logic [30:0] expected_q [$];

    dvi_tx_top dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_red       (i_red),
        .i_green     (i_green),
        .i_blue      (i_blue),
        .o_pix_strobe(o_pix_strobe),
        .o_tmds_d0   (o_tmds_d0),
        .o_tmds_d1   (o_tmds_d1),
        .o_tmds_d2   (o_tmds_d2),
        .o_tmds_clk  (o_tmds_clk)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    function automatic string lane_name(input int ch);
        case (ch)
            0:       return "blue";
            1:       return "green";
            default: return "red";
        endcase
    endfunction

    // ones minus zeros of one serial word
    function automatic int imbalance(input logic [9:0] word);
        int d;
        d = 0;
        for (int i = 0; i < 10; i++) begin
            d += word[i] ? 1 : -1;
        end
        return d;
    endfunction

    task automatic drive_colors();
        logic [31:0] rnd;
        rnd = $random(seed);
        i_red = rnd[7:0];
        i_green = rnd[15:8];
        i_blue = rnd[23:16];
    endtask

    task automatic check_word();
        logic [30:0] expected;
        logic [30:0] next_entry;
        logic [9:0]  clk_expected;
        clk_expected = (words_done == 0) ? 10'd0 : CLK_PATTERN;
        check_value($sformatf("clock lane word %0d", words_done),
                    lane_word[3], clk_expected);
        expected = expected_q.pop_front();
        for (int ch = 0; ch < 3; ch++) begin
            check_value($sformatf("%s lane word %0d", lane_name(ch), words_done),
                        lane_word[ch], expected[ch*10 +: 10]);
            // the span restarts after each blanking word
            if (expected[30]) begin
                lane_disp[ch] += imbalance(lane_word[ch]);
                check_value($sformatf("%s lane balance %0d at word %0d", lane_name(ch),
                                      lane_disp[ch], words_done),
                            (lane_disp[ch] >= -8 && lane_disp[ch] <= 8), 1);
            end else begin
                lane_disp[ch] = 0;
            end
        end
        // colors held during this word come out two words later
        model_word(i_red, i_green, i_blue, next_entry);
        expected_q.push_back(next_entry);
        words_done++;
    endtask

    task automatic sample_cycle();
        if (drive_pending) begin
            drive_colors();
            drive_pending = 1'b0;
        end
        lane_word[0] = {o_tmds_d0, lane_word[0][9:1]};
        lane_word[1] = {o_tmds_d1, lane_word[1][9:1]};
        lane_word[2] = {o_tmds_d2, lane_word[2][9:1]};
        lane_word[3] = {o_tmds_clk, lane_word[3][9:1]};
        check_value("strobe cadence", o_pix_strobe, (since_strobe == SYMBOL_BITS - 1));
        // the strobe cycle shows bit 9 and completes the word
        if (o_pix_strobe) begin
            check_word();
            since_strobe = 0;
            drive_pending = 1'b1;
        end else begin
            since_strobe++;
        end
    endtask

    initial begin
        seed = 32'hab00600b;
        errors = 0;
        checks = 0;
        words_done = 0;
        since_strobe = 0;
        drive_pending = 1'b0;
        model_pos = 0;
        i_rst = 1'b1;
        drive_colors();
        for (int i = 0; i < 4; i++) begin
            lane_word[i] = '0;
        end
        for (int ch = 0; ch < 3; ch++) begin
            lane_disp[ch] = 0;
            model_cnt[ch] = 0;
        end
        // words 0 and 1 carry the reset symbol
        expected_q.push_back(31'd0);
        expected_q.push_back(31'd0);
        repeat (RESET_CYCLES) begin
            @(negedge i_clk);
            check_value("outputs during reset",
                        {o_pix_strobe, o_tmds_clk, o_tmds_d2, o_tmds_d1, o_tmds_d0}, 0);
        end
        i_rst = 1'b0;
        // this negedge already shows bit 0 of word 0
        sample_cycle();
        while (words_done < TOTAL_WORDS) begin
            @(negedge i_clk);
            sample_cycle();
        end
        $display("words %0d, checks %0d, errors %0d", words_done, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles with %0d of %0d words checked",
                 WATCHDOG_CYCLES, words_done, TOTAL_WORDS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
+incdir+verification
logic/tmds_pkg.sv
logic/video_timing.sv
logic/tmds_gen.sv
logic/tmds_serializer.sv
logic/dvi_tx_top.sv
verification/tb_dvi_tx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the DVI transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_dvi_tx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dvi_tx)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^\*\*\* TEST PASSED \*\*\*$'; then
    exit 0
fi
exit 1
